//--- verification/program_cases.txt
# inst     we rd data     next_pc   (hex, one executed instruction per line, trace starts at 80000000)
# rd and data are only checked when we is 1
00500093 1 01 00000005 80000004  # addi x1, x0, 5
ffd00113 1 02 fffffffd 80000008  # addi x2, x0, -3
002081b3 1 03 00000002 8000000c  # add x3, x1, x2
40208233 1 04 00000008 80000010  # sub x4, x1, x2
001092b3 1 05 000000a0 80000014  # sll x5, x1, x1
00112333 1 06 00000001 80000018  # slt x6, x2, x1
001133b3 1 07 00000000 8000001c  # sltu x7, x2, x1
0020c433 1 08 fffffff8 80000020  # xor x8, x1, x2
001154b3 1 09 07ffffff 80000024  # srl x9, x2, x1
40115533 1 0a ffffffff 80000028  # sra x10, x2, x1
0020e5b3 1 0b fffffffd 8000002c  # or x11, x1, x2
0020f633 1 0c 00000005 80000030  # and x12, x1, x2
ffe12693 1 0d 00000001 80000034  # slti x13, x2, -2
fff0b713 1 0e 00000001 80000038  # sltiu x14, x1, -1
7ff0c793 1 0f 000007fa 8000003c  # xori x15, x1, 0x7ff
1000e813 1 10 00000105 80000040  # ori x16, x1, 0x100
0f017893 1 11 000000f0 80000044  # andi x17, x2, 0xf0
01c09913 1 12 50000000 80000048  # slli x18, x1, 28
01c15993 1 13 0000000f 8000004c  # srli x19, x2, 28
40115a13 1 14 fffffffe 80000050  # srai x20, x2, 1
12345ab7 1 15 12345000 80000054  # lui x21, 0x12345
00001b17 1 16 80001054 80000058  # auipc x22, 0x1
00708013 0 00 00000000 8000005c  # addi x0, x1, 7
00100bb3 1 17 00000005 80000060  # add x23, x0, x1
00108463 0 00 00000000 80000068  # beq x1, x1, +8 taken
00208463 0 00 00000000 8000006c  # beq x1, x2, +8 not taken
00209463 0 00 00000000 80000074  # bne x1, x2, +8 taken
00109463 0 00 00000000 80000078  # bne x1, x1, +8 not taken
00114463 0 00 00000000 80000080  # blt x2, x1, +8 taken
0020c463 0 00 00000000 80000084  # blt x1, x2, +8 not taken
0020d463 0 00 00000000 8000008c  # bge x1, x2, +8 taken
00115463 0 00 00000000 80000090  # bge x2, x1, +8 not taken
0020e463 0 00 00000000 80000098  # bltu x1, x2, +8 taken
00116463 0 00 00000000 8000009c  # bltu x2, x1, +8 not taken
00117463 0 00 00000000 800000a4  # bgeu x2, x1, +8 taken
0020f463 0 00 00000000 800000a8  # bgeu x1, x2, +8 not taken
01000c6f 1 18 800000ac 800000b8  # jal x24, +16
021c0ce7 1 19 800000bc 800000cc  # jalr x25, 0x21(x24)
018c8d33 1 1a 00000168 800000d0  # add x26, x25, x24
ff9ff06f 0 00 00000000 800000c8  # jal x0, -8

//--- sim.f
rtl/rv_pkg.sv
rtl/pc_unit.sv
rtl/reg_file.sv
rtl/decoder.sv
rtl/alu.sv
rtl/rv_core.sv
verification/core_asserts.sv
verification/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module core_tb -o core_tb_sim
./obj_dir/core_tb_sim

//--- verification/core_tb.sv
`timescale 1ns/1ps

module core_tb import rv_pkg::*; ();
    localparam word_t START_PC   = 32'h8000_0000;  // pc expected after reset
    localparam word_t IDLE_INST  = 32'h0000_006f;  // jal x0, 0 keeps pc parked
    localparam int    MAX_WAIT   = 20;
    localparam int    MAX_CYCLES = 200;

    logic  clk;
    logic  reset;
    word_t inst;
    word_t pc;
    wb_t   wb;

    word_t case_inst [$];
    wb_t   case_wb [$];
    word_t case_npc [$];

    rv_core dut_i (
        .clk   (clk),
        .reset (reset),
        .inst  (inst),
        .pc    (pc),
        .wb    (wb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        inst  = IDLE_INST;
        repeat (3) @(negedge clk);
        reset = 1'b0;
    end

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        $display("Test failures found");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("error: %s", msg);
        $display("Test failures found");
        $fatal(1, "run aborted");
    endtask

    task automatic check_pc(input word_t got, input word_t exp, input int idx);
        if (got !== exp) begin
            report_mismatch($sformatf("case %0d pc got %h expected %h", idx, got, exp));
        end
    endtask

    // rd and data only matter when a write happens
    task automatic check_wb(input wb_t got, input wb_t exp, input int idx);
        if (got.we !== exp.we) begin
            report_mismatch($sformatf("case %0d wb.we got %b expected %b", idx, got.we, exp.we));
        end else if (exp.we && got.rd !== exp.rd) begin
            report_mismatch($sformatf("case %0d wb.rd got %0d expected %0d", idx, got.rd, exp.rd));
        end else if (exp.we && got.data !== exp.data) begin
            report_mismatch($sformatf("case %0d wb.data got %h expected %h",
                                      idx, got.data, exp.data));
        end
    endtask

    task automatic load_cases();
        int    fd;
        int    n;
        string line;
        word_t f_inst;
        word_t f_we;
        word_t f_rd;
        word_t f_data;
        word_t f_npc;
        wb_t   w;
        fd = $fopen("verification/program_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verification/program_cases.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 0 && line[0] != "#") begin  // skip header
                n = $sscanf(line, "%h %h %h %h %h", f_inst, f_we, f_rd, f_data, f_npc);
                if (n == 5) begin
                    w.we   = f_we[0];
                    w.rd   = f_rd[REG_ADDR_W-1:0];
                    w.data = f_data;
                    case_inst.push_back(f_inst);
                    case_wb.push_back(w);
                    case_npc.push_back(f_npc);
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int    cycles;
        word_t exp_pc;
        load_cases();
        if (case_inst.size() == 0) begin
            abort_run("no cases found in verification/program_cases.txt");
        end
        cycles = 0;
        while (reset !== 1'b0) begin  // reset is stable at the rising edge
            @(posedge clk);
            cycles++;
            if (cycles > MAX_WAIT) begin
                abort_run("reset was not released in time");
            end
        end
        @(negedge clk);
        exp_pc = START_PC;
        cycles = 0;
        for (int i = 0; i < case_inst.size(); i++) begin
            check_pc(pc, exp_pc, i);
            inst = case_inst[i];
            #5;  // wb settles within the cycle
            check_wb(wb, case_wb[i], i);
            exp_pc = case_npc[i];
            @(negedge clk);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                abort_run("instruction trace did not finish within the cycle limit");
            end
        end
        check_pc(pc, exp_pc, case_inst.size());  // next pc of the last instruction
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- verification/core_asserts.sv
`timescale 1ns/1ps

module core_asserts import rv_pkg::*; #(
    parameter word_t RESET_PC = 32'h8000_0000
) (
    input logic  clk,
    input logic  reset,
    input word_t pc,
    input wb_t   wb
);
    no_x0_write: assert property (@(posedge clk) disable iff (reset) wb.we |-> wb.rd != '0)
        else $error("register write enabled with rd equal to x0");

    pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc is not a multiple of four");

    // reset loads the start address at every edge it is held
    pc_after_reset: assert property (@(posedge clk) reset |=> pc == RESET_PC)
        else $error("pc differs from the reset address after reset");

endmodule

bind rv_core core_asserts #(.RESET_PC(RESET_PC)) core_asserts_i (
    .clk   (clk),
    .reset (reset),
    .pc    (pc),
    .wb    (wb)
);

//--- rtl/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
    parameter word_t RESET_PC = 32'h8000_0000
) (
    input  logic  clk,
    input  logic  reset,
    input  word_t inst,
    output word_t pc,
    output wb_t   wb
);
    ctrl_t     ctrl;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     imm;
    word_t     rdata1;
    word_t     rdata2;
    word_t     result;
    word_t     wb_data;
    word_t     snpc;
    logic      taken;

    decoder decoder_i (
        .inst (inst),
        .ctrl (ctrl),
        .rs1  (rs1),
        .rs2  (rs2),
        .rd   (rd),
        .imm  (imm)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .we     (wb.we),
        .waddr  (wb.rd),
        .wdata  (wb.data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    alu alu_i (
        .ctrl    (ctrl),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .imm     (imm),
        .pc      (pc),
        .snpc    (snpc),
        .result  (result),
        .wb_data (wb_data),
        .taken   (taken)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) pc_unit_i (
        .clk       (clk),
        .reset     (reset),
        .jump_kind (ctrl.jump_kind),
        .taken     (taken),
        .target    (result),
        .pc        (pc),
        .snpc      (snpc)
    );

    always_comb begin
        wb.we   = ctrl.reg_we && !reset;  // no writes while in reset
        wb.rd   = rd;
        wb.data = wb_data;
    end

endmodule

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  ctrl_t ctrl,
    input  word_t rdata1,
    input  word_t rdata2,
    input  word_t imm,
    input  word_t pc,
    input  word_t snpc,
    output word_t result,
    output word_t wb_data,
    output logic  taken
);
    word_t      op_a;
    word_t      op_b;
    logic [4:0] shamt;

    always_comb begin
        case (ctrl.a_sel)
            A_PC:    op_a = pc;
            A_ZERO:  op_a = '0;
            default: op_a = rdata1;
        endcase
    end

    assign op_b  = (ctrl.b_sel == B_IMM) ? imm : rdata2;
    assign shamt = op_b[4:0];  // only low five bits shift

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = word_t'($signed(op_a) >>> shamt);
            ALU_OR:   result = op_a | op_b;
            ALU_AND:  result = op_a & op_b;
            default:  result = op_a + op_b;
        endcase
    end

    // branch compare always works on the registers
    always_comb begin
        case (ctrl.br_cond)
            BR_NE:   taken = rdata1 != rdata2;
            BR_LT:   taken = $signed(rdata1) < $signed(rdata2);
            BR_GE:   taken = $signed(rdata1) >= $signed(rdata2);
            BR_LTU:  taken = rdata1 < rdata2;
            BR_GEU:  taken = rdata1 >= rdata2;
            default: taken = rdata1 == rdata2;
        endcase
    end

    assign wb_data = (ctrl.wb_sel == WB_PC4) ? snpc : result;  // return address for jal/jalr

endmodule

//--- rtl/decoder.sv
`timescale 1ns/1ps

module decoder import rv_pkg::*; (
    input  word_t     inst,
    output ctrl_t     ctrl,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    output reg_addr_t rd,
    output word_t     imm
);
    opcode_t    opcode;
    logic [2:0] funct3;
    alu_op_t    arith_op;     // alu op of the OP / OP_IMM group
    br_cond_t   branch_cond;
    logic       branch_ok;    // funct3 names a real branch
    logic       writes_rd;

    assign opcode = opcode_t'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];

    always_comb begin
        case (opcode)
            OP_IMM, JALR: imm = {{20{inst[31]}}, inst[31:20]};
            BRANCH:       imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            LUI, AUIPC:   imm = {inst[31:12], 12'b0};
            JAL:          imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:      imm = '0;  // R form has no immediate
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000: arith_op = (opcode == OP && inst[30]) ? ALU_SUB : ALU_ADD;
            3'b001: arith_op = ALU_SLL;
            3'b010: arith_op = ALU_SLT;
            3'b011: arith_op = ALU_SLTU;
            3'b100: arith_op = ALU_XOR;
            3'b101: arith_op = inst[30] ? ALU_SRA : ALU_SRL;  // funct7 bit 5
            3'b110: arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        branch_ok = 1'b1;
        case (funct3)
            3'b000: branch_cond = BR_EQ;
            3'b001: branch_cond = BR_NE;
            3'b100: branch_cond = BR_LT;
            3'b101: branch_cond = BR_GE;
            3'b110: branch_cond = BR_LTU;
            3'b111: branch_cond = BR_GEU;
            default: begin
                branch_cond = BR_EQ;
                branch_ok   = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl.alu_op    = ALU_ADD;
        ctrl.a_sel     = A_RS1;
        ctrl.b_sel     = B_IMM;
        ctrl.br_cond   = branch_cond;
        ctrl.jump_kind = JMP_NONE;
        ctrl.wb_sel    = WB_ALU;
        writes_rd      = 1'b0;
        case (opcode)
            OP: begin
                ctrl.alu_op = arith_op;
                ctrl.b_sel  = B_RS2;
                writes_rd   = 1'b1;
            end
            OP_IMM: begin
                ctrl.alu_op = arith_op;
                writes_rd   = 1'b1;
            end
            LUI: begin
                ctrl.a_sel = A_ZERO;  // 0 + upper imm
                writes_rd  = 1'b1;
            end
            AUIPC: begin
                ctrl.a_sel = A_PC;
                writes_rd  = 1'b1;
            end
            BRANCH: begin
                ctrl.a_sel     = A_PC;  // alu forms the target
                ctrl.jump_kind = branch_ok ? JMP_BRANCH : JMP_NONE;
            end
            JAL: begin
                ctrl.a_sel     = A_PC;
                ctrl.jump_kind = JMP_JAL;
                ctrl.wb_sel    = WB_PC4;
                writes_rd      = 1'b1;
            end
            JALR: begin
                ctrl.jump_kind = JMP_JALR;
                ctrl.wb_sel    = WB_PC4;
                writes_rd      = 1'b1;
            end
            default: ;  // unknown opcode writes nothing, no jump
        endcase
        ctrl.reg_we = writes_rd && (rd != '0);
    end

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      we,
    input  reg_addr_t waddr,
    input  word_t     wdata,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output word_t     rdata1,
    output word_t     rdata2
);
    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // x0 always reads zero, no write bypass
    always_comb begin
        rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
        rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
    end

endmodule

//--- rtl/pc_unit.sv
`timescale 1ns/1ps

module pc_unit import rv_pkg::*; #(
    parameter word_t RESET_PC = 32'h8000_0000
) (
    input  logic       clk,
    input  logic       reset,
    input  jump_kind_t jump_kind,
    input  logic       taken,
    input  word_t      target,
    output word_t      pc,
    output word_t      snpc
);
    word_t dnpc;  // next pc actually taken

    assign snpc = pc + 32'd4;

    always_comb begin
        case (jump_kind)
            JMP_JAL:    dnpc = target;
            JMP_JALR:   dnpc = {target[XLEN-1:1], 1'b0};  // low bit cleared
            JMP_BRANCH: dnpc = taken ? target : snpc;
            default:    dnpc = snpc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= dnpc;
        end
    end

endmodule

//--- rtl/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_sel_t;
    typedef enum logic {B_RS2, B_IMM} b_sel_t;

    // encoded like funct3 of the branch group
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_t;

    typedef enum logic [1:0] {JMP_NONE, JMP_BRANCH, JMP_JAL, JMP_JALR} jump_kind_t;

    typedef enum logic {WB_ALU, WB_PC4} wb_sel_t;

    typedef struct packed {
        alu_op_t    alu_op;
        a_sel_t     a_sel;
        b_sel_t     b_sel;
        br_cond_t   br_cond;
        jump_kind_t jump_kind;
        wb_sel_t    wb_sel;
        logic       reg_we;
    } ctrl_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage
